// File: source/rtc_cfg.svh
// rtc chip constants
`ifndef RTC_CFG_SVH
`define RTC_CFG_SVH

// write addresses, the read address has bit 0 set
`define RTC_ADDR_SECOND 8'h80
`define RTC_ADDR_MINUTE 8'h82
`define RTC_ADDR_HOUR   8'h84
`define RTC_ADDR_CTRL   8'h8E

// system clocks per sclk half period
`define RTC_SCLK_DIV 4

// field limits in bcd
`define RTC_HOUR_MAX   8'h23
`define RTC_MINSEC_MAX 8'h59

`define RTC_CH_BIT 7        // clock halt in seconds reg
`define RTC_WP_ON  8'h80    // control reg, write protect set
`define RTC_WP_OFF 8'h00

`endif

// File: source/rtc_pkg.sv
// rtc shared types
package rtc_pkg;

    // one-hot chip commands, zero means nothing pending
    typedef enum logic [7:0] {
        cmd_none            = 8'h00,
        cmd_write_unprotect = 8'h80,
        cmd_write_hour      = 8'h40,
        cmd_write_minute    = 8'h20,
        cmd_write_second    = 8'h10,
        cmd_write_protect   = 8'h08,
        cmd_read_hour       = 8'h04,
        cmd_read_minute     = 8'h02,
        cmd_read_second     = 8'h01
    } rtc_cmd_t;

    // field under edit in config mode
    typedef enum logic [1:0] {
        field_hour   = 2'd0,
        field_minute = 2'd1,
        field_second = 2'd2
    } rtc_field_e;

    // packed bcd time, hour in the top byte
    typedef struct packed {
        logic [7:0] hour;
        logic [7:0] minute;
        logic [7:0] second;
    } rtc_time_t;

endpackage

// File: source/rtc_cmd_if.sv
// rtc command channel
`timescale 1ns/1ps

interface rtc_cmd_if import rtc_pkg::*; ();

    rtc_cmd_t   cmd;    // held until done
    logic [7:0] wdata;
    logic       done;   // one cycle, after ce drops
    logic [7:0] rdata;  // valid with done

    modport ctrl (
        output cmd,
        output wdata,
        input  done,
        input  rdata
    );

    modport link (
        input  cmd,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// File: source/rtc_control.sv
// rtc mode sequencer
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module rtc_control import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_toggle,
    input  logic      key_next,
    input  logic      key_up,
    input  logic      key_down,
    output rtc_time_t time_now,
    output logic      config_active,
    rtc_cmd_if.ctrl   bus
);

    localparam logic [7:0] CH_MASK = 8'(1 << `RTC_CH_BIT);

    typedef enum logic [3:0] {
        ST_RD_HOUR,
        ST_RD_MINUTE,
        ST_RD_SECOND,
        ST_WR_UNPROT,
        ST_WR_HOUR,
        ST_WR_MINUTE,
        ST_WR_SECOND,
        ST_WR_PROT,
        ST_CHECK,
        ST_CFG_UNPROT,
        ST_CFG_HALT,
        ST_EDIT
    } state_t;

    state_t     state;
    state_t     state_done;     // where to go once done arrives
    logic       config_mode;
    logic       init_done;
    rtc_field_e field;
    logic       pend_next;
    logic       pend_up;
    logic       pend_down;
    logic       next_req;
    logic       up_req;
    logic       down_req;
    rtc_cmd_t   cmd_req;
    logic [7:0] wdata_req;
    logic [7:0] sel_val;
    logic [7:0] sel_max;
    logic [7:0] edit_val;
    rtc_time_t  edit_time;

    function automatic logic [7:0] bcd_inc(input logic [7:0] v, input logic [7:0] lim);
        if (v >= lim)
            return lim;
        else if (v[3:0] == 4'd9)
            return {v[7:4] + 4'd1, 4'd0};   // carry into tens
        else
            return v + 8'd1;
    endfunction

    function automatic logic [7:0] bcd_dec(input logic [7:0] v);
        if (v[3:0] != 4'd0)
            return v - 8'd1;
        else if (v[7:4] != 4'd0)
            return {v[7:4] - 4'd1, 4'd9};   // borrow from tens
        else
            return 8'h00;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            config_mode <= 1'b0;
        else if (key_toggle)
            config_mode <= ~config_mode;
    end

    assign config_active = config_mode;

    assign next_req = key_next | pend_next;
    assign up_req   = key_up | pend_up;
    assign down_req = key_down | pend_down;

    // command and follow-on state for each transaction step
    always_comb
    begin
        cmd_req    = cmd_none;
        wdata_req  = 8'h00;
        state_done = ST_CHECK;
        case (state)
            ST_RD_HOUR:
            begin
                cmd_req    = cmd_read_hour;
                state_done = ST_RD_MINUTE;
            end
            ST_RD_MINUTE:
            begin
                cmd_req    = cmd_read_minute;
                state_done = ST_RD_SECOND;
            end
            ST_RD_SECOND:
            begin
                cmd_req    = cmd_read_second;
                state_done = init_done ? ST_CHECK : ST_WR_UNPROT;
            end
            ST_WR_UNPROT:
            begin
                cmd_req    = cmd_write_unprotect;
                wdata_req  = `RTC_WP_OFF;
                state_done = ST_WR_HOUR;
            end
            ST_WR_HOUR:
            begin
                cmd_req    = cmd_write_hour;
                wdata_req  = time_now.hour;
                state_done = ST_WR_MINUTE;
            end
            ST_WR_MINUTE:
            begin
                cmd_req    = cmd_write_minute;
                wdata_req  = time_now.minute;
                state_done = ST_WR_SECOND;
            end
            ST_WR_SECOND:
            begin
                cmd_req    = cmd_write_second;
                wdata_req  = time_now.second & ~CH_MASK;    // oscillator runs
                state_done = ST_WR_PROT;
            end
            ST_WR_PROT:
            begin
                cmd_req    = cmd_write_protect;
                wdata_req  = `RTC_WP_ON;
            end
            ST_CFG_UNPROT:
            begin
                cmd_req    = cmd_write_unprotect;
                wdata_req  = `RTC_WP_OFF;
                state_done = ST_CFG_HALT;
            end
            ST_CFG_HALT:
            begin
                cmd_req    = cmd_write_second;
                wdata_req  = time_now.second | CH_MASK;     // stop the chip clock
                state_done = ST_EDIT;
            end
            default: ;
        endcase
    end

    // selected field and its edited value
    always_comb
    begin
        case (field)
            field_minute:
            begin
                sel_val = time_now.minute;
                sel_max = `RTC_MINSEC_MAX;
            end
            field_second:
            begin
                sel_val = time_now.second;
                sel_max = `RTC_MINSEC_MAX;
            end
            default:
            begin
                sel_val = time_now.hour;
                sel_max = `RTC_HOUR_MAX;
            end
        endcase
        edit_val  = up_req ? bcd_inc(sel_val, sel_max) : bcd_dec(sel_val);
        edit_time = time_now;
        case (field)
            field_minute: edit_time.minute = edit_val;
            field_second: edit_time.second = edit_val;
            default:      edit_time.hour   = edit_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_RD_HOUR;
            init_done <= 1'b0;
            field     <= field_hour;
            time_now  <= '0;
            pend_next <= 1'b0;
            pend_up   <= 1'b0;
            pend_down <= 1'b0;
            bus.cmd   <= cmd_none;
            bus.wdata <= 8'h00;
        end
        else
        begin
            // keys seen mid-transaction wait for the edit state
            pend_next <= (pend_next | key_next) & config_mode;
            pend_up   <= (pend_up | key_up) & config_mode;
            pend_down <= (pend_down | key_down) & config_mode;
            case (state)
                ST_CHECK:
                    state <= config_mode ? ST_CFG_UNPROT : ST_RD_HOUR;
                ST_EDIT:
                begin
                    if (!config_mode)
                        state <= ST_WR_HOUR;    // write back and restart clock
                    else if (next_req)
                    begin
                        pend_next <= 1'b0;
                        case (field)
                            field_hour:   field <= field_minute;
                            field_minute: field <= field_second;
                            default:      field <= field_hour;
                        endcase
                    end
                    else if (up_req)
                    begin
                        pend_up  <= 1'b0;
                        time_now <= edit_time;
                    end
                    else if (down_req)
                    begin
                        pend_down <= 1'b0;
                        time_now  <= edit_time;
                    end
                end
                default:
                begin
                    if (bus.done)
                    begin
                        bus.cmd <= cmd_none;
                        state   <= state_done;
                        case (state)
                            ST_RD_HOUR:    time_now.hour   <= bus.rdata & 8'h3F; // 24h bits
                            ST_RD_MINUTE:  time_now.minute <= bus.rdata & 8'h7F;
                            ST_RD_SECOND:  time_now.second <= bus.rdata & ~CH_MASK;
                            ST_WR_PROT:    init_done       <= 1'b1;
                            ST_CFG_UNPROT: field           <= field_hour;
                            default: ;
                        endcase
                    end
                    else
                    begin
                        bus.cmd   <= cmd_req;
                        bus.wdata <= wdata_req;
                    end
                end
            endcase
        end
    end

    a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bus.cmd));

    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.cmd != cmd_none && !bus.done)
        |=> (bus.cmd == $past(bus.cmd) && bus.wdata == $past(bus.wdata)));

    a_bcd_range: assert property (@(posedge clk) disable iff (!rst_n)
        time_now.hour[3:0] <= 4'd9 && time_now.hour <= `RTC_HOUR_MAX
        && time_now.minute[3:0] <= 4'd9 && time_now.minute <= `RTC_MINSEC_MAX
        && time_now.second[3:0] <= 4'd9 && time_now.second <= `RTC_MINSEC_MAX);

endmodule

// File: source/ds1302_link.sv
// ds1302 three-wire serial engine
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module ds1302_link import rtc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    rtc_cmd_if.link bus,
    output logic    rtc_ce,
    output logic    rtc_sclk,
    output logic    rtc_io_out,
    output logic    rtc_io_oe,
    input  logic    rtc_io_in
);

    localparam logic [7:0] DIV_LAST = 8'(`RTC_SCLK_DIV - 1);

    typedef enum logic [2:0] {
        LK_IDLE,
        LK_SETUP,
        LK_SHIFT,
        LK_HOLD,
        LK_DONE
    } link_state_t;

    link_state_t state;
    logic [7:0]  div_cnt;
    logic        tick;          // end of a half period
    logic        start;
    logic        sclk_hi;
    logic [3:0]  bit_cnt;       // 0..7 address, 8..15 data
    logic        is_read;
    logic [15:0] tx_shift;
    logic [7:0]  rx_shift;

    function automatic logic [7:0] cmd_addr(input rtc_cmd_t c);
        case (c)
            cmd_write_hour:   return `RTC_ADDR_HOUR;
            cmd_write_minute: return `RTC_ADDR_MINUTE;
            cmd_write_second: return `RTC_ADDR_SECOND;
            cmd_read_hour:    return `RTC_ADDR_HOUR | 8'h01;
            cmd_read_minute:  return `RTC_ADDR_MINUTE | 8'h01;
            cmd_read_second:  return `RTC_ADDR_SECOND | 8'h01;
            default:          return `RTC_ADDR_CTRL;  // protect and unprotect
        endcase
    endfunction

    assign tick  = (div_cnt == DIV_LAST);
    assign start = (state == LK_IDLE) && (bus.cmd != cmd_none);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= LK_IDLE;
            div_cnt <= 8'd0;
            sclk_hi <= 1'b0;
            bit_cnt <= 4'd0;
            is_read <= 1'b0;
        end
        else
        begin
            if (tick || state == LK_IDLE || state == LK_DONE)
                div_cnt <= 8'd0;
            else
                div_cnt <= div_cnt + 8'd1;
            case (state)
                LK_IDLE:
                begin
                    if (start)
                    begin
                        state   <= LK_SETUP;
                        is_read <= bus.cmd inside {cmd_read_hour, cmd_read_minute,
                                                   cmd_read_second};
                    end
                end
                LK_SETUP:
                begin
                    if (tick)
                    begin
                        state   <= LK_SHIFT;
                        bit_cnt <= 4'd0;
                        sclk_hi <= 1'b0;
                    end
                end
                LK_SHIFT:
                begin
                    if (tick)
                    begin
                        sclk_hi <= ~sclk_hi;
                        if (sclk_hi)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;  // wraps after the last bit
                            if (bit_cnt == 4'd15)
                                state <= LK_HOLD;
                        end
                    end
                end
                LK_HOLD:
                begin
                    if (tick)
                        state <= LK_DONE;
                end
                default:
                    state <= LK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            tx_shift <= {bus.wdata, cmd_addr(bus.cmd)};
        else if (state == LK_SHIFT && tick && sclk_hi)
            tx_shift <= {1'b0, tx_shift[15:1]};     // next bit on the falling edge
        // chip drives on the fall, sampled at the end of the low phase
        if (state == LK_SHIFT && tick && !sclk_hi && is_read && bit_cnt[3])
            rx_shift <= {rtc_io_in, rx_shift[7:1]};
    end

    assign rtc_ce     = (state == LK_SETUP) || (state == LK_SHIFT) || (state == LK_HOLD);
    assign rtc_sclk   = (state == LK_SHIFT) && sclk_hi;
    assign rtc_io_out = tx_shift[0];
    assign rtc_io_oe  = (state == LK_SETUP) || (state == LK_SHIFT && !(is_read && bit_cnt[3]));

    assign bus.done  = (state == LK_DONE);
    assign bus.rdata = rx_shift;

    a_sclk_in_ce: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(rtc_sclk) |-> (rtc_ce && $past(rtc_ce)));

    a_done_after_ce: assert property (@(posedge clk) disable iff (!rst_n)
        bus.done |-> ($fell(rtc_ce) ##1 !bus.done));

endmodule

// File: source/rtc_top.sv
// rtc controller top
`timescale 1ns/1ps

module rtc_top import rtc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_toggle,
    input  logic        key_next,
    input  logic        key_up,
    input  logic        key_down,
    output logic [23:0] rtc_time,
    output logic        config_active,
    output logic        rtc_ce,
    output logic        rtc_sclk,
    output logic        rtc_io_out,
    output logic        rtc_io_oe,
    input  logic        rtc_io_in
);

    rtc_time_t time_now;

    rtc_cmd_if u_cmd_if ();

    rtc_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_toggle    (key_toggle),
        .key_next      (key_next),
        .key_up        (key_up),
        .key_down      (key_down),
        .time_now      (time_now),
        .config_active (config_active),
        .bus           (u_cmd_if.ctrl)
    );

    ds1302_link u_link (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (u_cmd_if.link),
        .rtc_ce     (rtc_ce),
        .rtc_sclk   (rtc_sclk),
        .rtc_io_out (rtc_io_out),
        .rtc_io_oe  (rtc_io_oe),
        .rtc_io_in  (rtc_io_in)
    );

    assign rtc_time = time_now;     // hour, minute, second

endmodule

// File: tests/ds1302_model.sv
// ds1302 behavioral model
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module ds1302_model
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ce,
    input  logic       sclk,
    input  logic       io_in,
    input  logic       sec_tick,
    output logic       io_out,
    output logic       io_oe,
    output logic [7:0] hour_reg,
    output logic [7:0] minute_reg,
    output logic [7:0] second_reg,
    output logic [7:0] ctrl_reg,
    output logic       protocol_error
);

    logic       sclk_q;
    logic [4:0] bit_n;      // rising edges seen in this frame
    logic [7:0] addr;
    logic [7:0] wdat;
    logic [7:0] rd_shift;
    logic [7:0] rd_val;
    logic [7:0] wr_byte;
    logic       drive;
    logic       rise;
    logic       fall;
    logic       wr_last;
    logic       err_flag = 1'b0;

    assign rise           = ce && sclk && !sclk_q;
    assign fall           = ce && !sclk && sclk_q;
    assign wr_last        = rise && (bit_n == 5'd15) && !addr[0];
    assign wr_byte        = {io_in, wdat[7:1]};
    assign io_oe          = ce && drive;
    assign protocol_error = err_flag;

    always_comb
    begin
        case ({addr[7:1], 1'b0})
            `RTC_ADDR_SECOND: rd_val = second_reg;
            `RTC_ADDR_MINUTE: rd_val = minute_reg;
            `RTC_ADDR_HOUR:   rd_val = hour_reg;
            `RTC_ADDR_CTRL:   rd_val = ctrl_reg;
            default:          rd_val = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sclk_q     <= 1'b0;
            bit_n      <= 5'd0;
            addr       <= 8'h00;
            wdat       <= 8'h00;
            rd_shift   <= 8'h00;
            drive      <= 1'b0;
            io_out     <= 1'b0;
            hour_reg   <= 8'h12;
            minute_reg <= 8'h34;
            second_reg <= 8'hD6;    // 56 with clock halted
            ctrl_reg   <= `RTC_WP_ON;
        end
        else
        begin
            sclk_q <= sclk;
            // oscillator, seconds only
            if (sec_tick && !second_reg[`RTC_CH_BIT])
            begin
                if (second_reg[3:0] != 4'd9)
                    second_reg <= second_reg + 8'd1;
                else if (second_reg[6:4] == 3'd5)
                    second_reg <= 8'h00;
                else
                    second_reg <= {second_reg[7:4] + 4'd1, 4'd0};
            end
            if (!ce)
            begin
                bit_n <= 5'd0;
                drive <= 1'b0;
            end
            else if (rise)
            begin
                if (bit_n < 5'd8)
                    addr <= {io_in, addr[7:1]};
                else
                    wdat <= wr_byte;
                bit_n <= bit_n + 5'd1;
                if (wr_last)
                begin
                    if ({addr[7:1], 1'b0} == `RTC_ADDR_CTRL)
                        ctrl_reg <= wr_byte;
                    else if (!ctrl_reg[7])
                    begin
                        case ({addr[7:1], 1'b0})
                            `RTC_ADDR_SECOND: second_reg <= wr_byte;
                            `RTC_ADDR_MINUTE: minute_reg <= wr_byte;
                            `RTC_ADDR_HOUR:   hour_reg   <= wr_byte;
                            default: ;
                        endcase
                    end
                end
            end
            else if (fall && bit_n >= 5'd8 && addr[0])
            begin
                drive <= 1'b1;      // read data goes out on falling edges
                if (bit_n == 5'd8)
                begin
                    io_out   <= rd_val[0];
                    rd_shift <= rd_val >> 1;
                end
                else
                begin
                    io_out   <= rd_shift[0];
                    rd_shift <= rd_shift >> 1;
                end
            end
        end
    end

    a_sixteen_bits: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ce) |-> (bit_n == 5'd16))
        else err_flag = 1'b1;

    a_cmd_bit: assert property (@(posedge clk) disable iff (!rst_n)
        (rise && bit_n == 5'd7) |-> io_in)
        else err_flag = 1'b1;

    a_write_protect: assert property (@(posedge clk) disable iff (!rst_n)
        wr_last |-> ({addr[7:1], 1'b0} == `RTC_ADDR_CTRL || !ctrl_reg[7]))
        else err_flag = 1'b1;

endmodule

// File: tests/tb_rtc_top.sv
// rtc controller testbench
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module tb_rtc_top;

    localparam int WAIT_LIMIT = 20000;

    logic        clk;
    logic        rst_n;
    logic        key_toggle;
    logic        key_next;
    logic        key_up;
    logic        key_down;
    logic        sec_tick;
    logic [23:0] rtc_time;
    logic        config_active;
    logic        rtc_ce;
    logic        rtc_sclk;
    logic        rtc_io_out;
    logic        rtc_io_oe;
    logic        io_line;
    logic        model_io_out;
    logic        model_io_oe;
    logic [7:0]  hour_reg;
    logic [7:0]  minute_reg;
    logic [7:0]  second_reg;
    logic [7:0]  ctrl_reg;
    logic        protocol_error;
    logic [23:0] exp_time;
    int          cnt;

    rtc_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_toggle    (key_toggle),
        .key_next      (key_next),
        .key_up        (key_up),
        .key_down      (key_down),
        .rtc_time      (rtc_time),
        .config_active (config_active),
        .rtc_ce        (rtc_ce),
        .rtc_sclk      (rtc_sclk),
        .rtc_io_out    (rtc_io_out),
        .rtc_io_oe     (rtc_io_oe),
        .rtc_io_in     (io_line)
    );

    ds1302_model u_chip (
        .clk            (clk),
        .rst_n          (rst_n),
        .ce             (rtc_ce),
        .sclk           (rtc_sclk),
        .io_in          (io_line),
        .sec_tick       (sec_tick),
        .io_out         (model_io_out),
        .io_oe          (model_io_oe),
        .hour_reg       (hour_reg),
        .minute_reg     (minute_reg),
        .second_reg     (second_reg),
        .ctrl_reg       (ctrl_reg),
        .protocol_error (protocol_error)
    );

    // io line with a pull-up
    assign io_line = rtc_io_oe ? rtc_io_out : (model_io_oe ? model_io_out : 1'b1);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int bcd_to_int(input logic [7:0] v);
        return int'(v[7:4]) * 10 + int'(v[3:0]);
    endfunction

    function automatic logic [7:0] int_to_bcd(input int n);
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    function automatic logic [7:0] step_up(input logic [7:0] v, input logic [7:0] lim);
        int n;
        n = bcd_to_int(v) + 1;
        if (n > bcd_to_int(lim))
            n = bcd_to_int(lim);
        return int_to_bcd(n);
    endfunction

    function automatic logic [7:0] step_down(input logic [7:0] v);
        int n;
        n = bcd_to_int(v) - 1;
        if (n < 0)
            n = 0;
        return int_to_bcd(n);
    endfunction

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [23:0] got, input logic [23:0] exp,
                               input string what);
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // one-cycle pulse then 4 cycles for the edit state to act
    task automatic press_key(input int which);
        @(negedge clk);
        case (which)
            0: key_toggle = 1'b1;
            1: key_next = 1'b1;
            2: key_up = 1'b1;
            default: key_down = 1'b1;
        endcase
        @(negedge clk);
        key_toggle = 1'b0;
        key_next   = 1'b0;
        key_up     = 1'b0;
        key_down   = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (!protocol_error)
            else
            begin
                $display("The chip model saw a serial protocol violation");
                $display("Regression failed");
                $fatal(1);
            end
            assert (!(rtc_io_oe && model_io_oe))
            else
            begin
                $display("Both the DUT and the chip model drive the io line");
                $display("Regression failed");
                $fatal(1);
            end
        end
    end

    initial
    begin
        rst_n      = 1'b0;
        key_toggle = 1'b0;
        key_next   = 1'b0;
        key_up     = 1'b0;
        key_down   = 1'b0;
        sec_tick   = 1'b0;
        exp_time   = 24'h123456;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // init reads and writes back with the oscillator running then protects
        cnt = 0;
        while (!(ctrl_reg == `RTC_WP_ON && !second_reg[`RTC_CH_BIT]))
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                report_timeout("the init sequence");
        end
        check_value(rtc_time, exp_time, "rtc_time after init");
        check_value({16'h0, second_reg}, 24'h56, "chip seconds after init");

        // normal mode follows the chip
        @(negedge clk);
        sec_tick = 1'b1;
        @(negedge clk);
        sec_tick = 1'b0;
        exp_time[7:0] = 8'h57;
        cnt = 0;
        while (rtc_time !== exp_time)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                report_timeout("rtc_time to follow the chip seconds");
        end

        press_key(0);
        check_value({23'h0, config_active}, 24'h1, "config_active after toggle");
        cnt = 0;
        while (!(ctrl_reg == `RTC_WP_OFF && second_reg[`RTC_CH_BIT] && !rtc_ce))
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                report_timeout("the chip to be unprotected and halted");
        end
        check_value({16'h0, second_reg}, 24'hD7, "chip seconds with halt bit");

        for (int i = 0; i < 12; i++)
        begin
            press_key(2);
            exp_time[23:16] = step_up(exp_time[23:16], `RTC_HOUR_MAX);
            check_value(rtc_time, exp_time, "rtc_time after hour up");
        end
        check_value({16'h0, rtc_time[23:16]}, 24'h23, "saturated hour");

        press_key(1);
        for (int i = 0; i < 40; i++)
        begin
            press_key(3);
            exp_time[15:8] = step_down(exp_time[15:8]);
            check_value(rtc_time, exp_time, "rtc_time after minute down");
        end

        press_key(1);
        for (int i = 0; i < 4; i++)
        begin
            press_key(2);
            exp_time[7:0] = step_up(exp_time[7:0], `RTC_MINSEC_MAX);
            check_value(rtc_time, exp_time, "rtc_time after second up");
        end
        check_value(rtc_time, 24'h230059, "edited time");

        // leaving config mode writes back and protects
        press_key(0);
        check_value({23'h0, config_active}, 24'h0, "config_active after second toggle");
        cnt = 0;
        while (!(ctrl_reg == `RTC_WP_ON && !second_reg[`RTC_CH_BIT]))
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                report_timeout("the write back after config mode");
        end
        check_value({hour_reg, minute_reg, second_reg}, exp_time, "chip time after write back");
        check_value(rtc_time, exp_time, "rtc_time after write back");

        $display("Regression passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/rtc_pkg.sv
source/rtc_cmd_if.sv
source/rtc_control.sv
source/ds1302_link.sv
source/rtc_top.sv
tests/ds1302_model.sv
tests/tb_rtc_top.sv

// File: Makefile
TOP = tb_rtc_top

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
